// ==== verilog/avg_pkg.sv ====
// avg_pkg: shared widths, filter length, register map and state
// encodings for the sample averaging pipeline

package avg_pkg;

  ////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////

  // sample and average width
  localparam int data_w = 16;

  // window is 2**filter_power samples
  localparam int filter_power = 3;
  localparam int filter_len = 1 << filter_power;

  // running sum, wide enough for a full window of extremes
  localparam int sum_w = data_w + filter_power;

  // decimation field, ratio is field + 1
  localparam int decim_w = 4;

  // clipped sample counter
  localparam int cnt_w = 16;

  ////////////////////////////////////////////////////////////
  // register map and bus states
  ////////////////////////////////////////////////////////////

  // word addresses on the wishbone port
  typedef enum logic [1:0] {
    reg_offset = 2'd0,
    reg_decim  = 2'd1,
    reg_ctrl   = 2'd2,
    reg_status = 2'd3
  } reg_addr_e;

  // classic single-cycle ack slave
  typedef enum logic {
    wb_idle = 1'b0,
    wb_ack  = 1'b1
  } wb_state_e;

endpackage

// ==== verilog/sample_if.sv ====
// sample_if: valid/ready stream between pipeline stages, carrying a
// signed sample and its clip flag

`timescale 1ns/10ps

interface sample_if import avg_pkg::*;;

  // handshake
  logic valid;
  logic ready;

  // payload, held stable until the transfer
  logic signed [data_w-1:0] data;
  logic clipped;

  // upstream side
  modport producer (
    output valid,
    output data,
    output clipped,
    input  ready
  );

  // downstream side
  modport consumer (
    input  valid,
    input  data,
    input  clipped,
    output ready
  );

endinterface

// ==== verilog/sample_clip.sv ====
// sample_clip: subtracts the programmed offset from each input sample
// and saturates to the signed sample range, flagging clipped results

`timescale 1ns/10ps

module sample_clip import avg_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  logic signed [data_w-1:0] in_data,
  input  logic signed [data_w-1:0] offset,
  output logic clip_event,
  sample_if.producer out
);

  // one bit of headroom for the subtraction
  logic [data_w:0] diff;
  logic sat_hi;
  logic sat_lo;
  logic accept;
  logic [data_w-1:0] sat_data;

  // register empty or drained this cycle
  assign in_ready = !out.valid || out.ready;
  assign accept = in_valid && in_ready;

  // sign extend both operands then subtract
  assign diff = {in_data[data_w-1], in_data} - {offset[data_w-1], offset};

  // top two bits disagree on overflow
  assign sat_hi = !diff[data_w] && diff[data_w-1];
  assign sat_lo = diff[data_w] && !diff[data_w-1];

  assign sat_data = sat_hi ? {1'b0, {(data_w-1){1'b1}}} :
                    sat_lo ? {1'b1, {(data_w-1){1'b0}}} :
                    diff[data_w-1:0];

  // counted by the register block
  assign clip_event = accept && (sat_hi || sat_lo);

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out.valid <= 1'b0;
    end else if (accept) begin
      out.valid <= 1'b1;
    end else if (out.ready) begin
      out.valid <= 1'b0;
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      out.data <= sat_data;
      out.clipped <= sat_hi || sat_lo;
    end
  end

  // boxcar stage must see every sample we offer
  a_valid_held: assert property (@(posedge clk) disable iff (rst)
    out.valid && !out.ready |=> out.valid);

endmodule

// ==== verilog/boxcar_avg.sv ====
// boxcar_avg: moving average over the last filter_len accepted samples,
// rounded toward zero, with an OR of the clip flags in the window

`timescale 1ns/10ps

module boxcar_avg import avg_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  sample_if.consumer in,
  sample_if.producer out
);

  // sample history, index 0 is newest
  logic [data_w-1:0] hist [filter_len];
  logic [filter_len-1:0] hist_clip;

  logic [sum_w-1:0] sum;
  logic [sum_w-1:0] sum_next;
  logic [sum_w-1:0] biased;
  logic [sum_w-1:0] hist_sum;
  logic [filter_len-1:0] win_clip;
  logic accept;

  assign in.ready = !out.valid || out.ready;
  assign accept = in.valid && in.ready;

  // add newest, drop oldest
  assign sum_next = sum
                  + {{filter_power{in.data[data_w-1]}}, in.data}
                  - {{filter_power{hist[filter_len-1][data_w-1]}}, hist[filter_len-1]};

  // bias negatives by len-1 so the shift rounds toward zero
  assign biased = sum_next + (sum_next[sum_w-1] ? sum_w'(filter_len - 1) : '0);

  // window after this sample enters
  assign win_clip = {hist_clip[filter_len-2:0], in.clipped};

  ////////////////////////////////////////////////////////////
  // history, running sum and output valid
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      for (int i = 0; i < filter_len; i++) begin
        hist[i] <= '0;
      end
      hist_clip <= '0;
      sum <= '0;
      out.valid <= 1'b0;
    end else if (accept) begin
      hist[0] <= in.data;
      for (int i = 1; i < filter_len; i++) begin
        hist[i] <= hist[i-1];
      end
      hist_clip <= win_clip;
      sum <= sum_next;
      out.valid <= 1'b1;
    end else if (out.ready) begin
      out.valid <= 1'b0;
    end
  end

  // upper bits of the biased sum are the divided average
  always_ff @(posedge clk) begin
    if (accept) begin
      out.data <= biased[sum_w-1:filter_power];
      out.clipped <= |win_clip;
    end
  end

  // reference sum of the stored history
  always_comb begin
    hist_sum = '0;
    for (int i = 0; i < filter_len; i++) begin
      hist_sum = hist_sum + {{filter_power{hist[i][data_w-1]}}, hist[i]};
    end
  end

  a_sum_tracks_hist: assert property (@(posedge clk) disable iff (rst)
    sum == hist_sum);

endmodule

// ==== verilog/avg_decimate.sv ====
// avg_decimate: passes every (decim+1)th average to the output register
// and consumes the rest

`timescale 1ns/10ps

module avg_decimate import avg_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic [decim_w-1:0] decim,
  sample_if.consumer in,
  output logic out_valid,
  input  logic out_ready,
  output logic signed [data_w-1:0] out_data,
  output logic out_clipped
);

  // averages accepted since the last kept one
  logic [decim_w-1:0] count;
  logic accept;
  logic keep;

  assign in.ready = !out_valid || out_ready;
  assign accept = in.valid && in.ready;
  assign keep = accept && (count == decim);

  ////////////////////////////////////////////////////////////
  // ratio counter and output valid
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      count <= '0;
      out_valid <= 1'b0;
    end else begin
      if (keep) begin
        count <= '0;
      end else if (accept) begin
        count <= count + 1'b1;
      end
      // dropped averages leave the register alone
      if (keep) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      out_data <= in.data;
      out_clipped <= in.clipped;
    end
  end

  // a stalled output must not change under the consumer
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready && !clear |=> out_valid && $stable(out_data));

endmodule

// ==== verilog/wb_regs.sv ====
// wb_regs: wishbone classic slave for offset, decimation, clear command
// and the saturating clipped-sample counter

`timescale 1ns/10ps

module wb_regs import avg_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic wb_cyc,
  input  logic wb_stb,
  input  logic wb_we,
  input  logic [1:0] wb_adr,
  input  logic [data_w-1:0] wb_dat_w,
  output logic [data_w-1:0] wb_dat_r,
  output logic wb_ack,
  input  logic clip_event,
  output logic signed [data_w-1:0] offset,
  output logic [decim_w-1:0] decim,
  output logic clear
);

  wb_state_e state;
  reg_addr_e adr;
  logic [cnt_w-1:0] clip_cnt;
  logic req;
  logic wr;
  logic cnt_full;

  assign adr = reg_addr_e'(wb_adr);

  // only sampled while idle, so one ack per request
  assign req = wb_cyc && wb_stb && (state == wb_idle);
  assign wr = req && wb_we;

  // ack follows the state directly
  assign wb_ack = (state == avg_pkg::wb_ack);

  assign cnt_full = &clip_cnt;

  ////////////////////////////////////////////////////////////
  // bus fsm and writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wb_idle;
      offset <= '0;
      decim <= '0;
      clear <= 1'b0;
    end else begin
      clear <= 1'b0;
      case (state)
        wb_idle: begin
          if (req) begin
            state <= avg_pkg::wb_ack;
          end
        end
        default: begin
          // back to idle whatever the master does
          state <= wb_idle;
        end
      endcase
      if (wr) begin
        case (adr)
          reg_offset: offset <= wb_dat_w;
          reg_decim:  decim <= wb_dat_w[decim_w-1:0];
          reg_ctrl:   clear <= wb_dat_w[0];
          default: ;
        endcase
      end
    end
  end

  // clip counter, status write wins over a clip
  always_ff @(posedge clk) begin
    if (rst) begin
      clip_cnt <= '0;
    end else if (wr && adr == reg_status) begin
      clip_cnt <= '0;
    end else if (clip_event && !cnt_full) begin
      clip_cnt <= clip_cnt + 1'b1;
    end
  end

  // read data valid alongside ack
  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      case (adr)
        reg_offset: wb_dat_r <= offset;
        reg_decim:  wb_dat_r <= data_w'(decim);
        reg_status: wb_dat_r <= data_w'(clip_cnt);
        default:    wb_dat_r <= '0;
      endcase
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack);

endmodule

// ==== verilog/avg_top.sv ====
// avg_top: offset/clip, boxcar average and decimator stages with their
// wishbone register block

`timescale 1ns/10ps

module avg_top import avg_pkg::*; (
  input  logic clk,
  input  logic rst,
  // sample input
  input  logic in_valid,
  output logic in_ready,
  input  logic signed [data_w-1:0] in_data,
  // averaged output
  output logic out_valid,
  input  logic out_ready,
  output logic signed [data_w-1:0] out_data,
  output logic out_clipped,
  // register port
  input  logic wb_cyc,
  input  logic wb_stb,
  input  logic wb_we,
  input  logic [1:0] wb_adr,
  input  logic [data_w-1:0] wb_dat_w,
  output logic [data_w-1:0] wb_dat_r,
  output logic wb_ack
);

  // configuration from the register block
  logic signed [data_w-1:0] offset;
  logic [decim_w-1:0] decim;
  logic clear;
  logic clip_event;

  ////////////////////////////////////////////////////////////
  // stage links
  ////////////////////////////////////////////////////////////

  sample_if clip_to_box ();
  sample_if box_to_dec ();

  sample_clip u_sample_clip (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
    .offset(offset), .clip_event(clip_event),
    .out(clip_to_box.producer)
  );

  boxcar_avg u_boxcar_avg (
    .clk(clk), .rst(rst), .clear(clear),
    .in(clip_to_box.consumer), .out(box_to_dec.producer)
  );

  avg_decimate u_avg_decimate (
    .clk(clk), .rst(rst), .clear(clear), .decim(decim),
    .in(box_to_dec.consumer),
    .out_valid(out_valid), .out_ready(out_ready),
    .out_data(out_data), .out_clipped(out_clipped)
  );

  wb_regs u_wb_regs (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .clip_event(clip_event),
    .offset(offset), .decim(decim), .clear(clear)
  );

endmodule

// ==== sim/tb_avg_top.sv ====
// testbench for avg_top, random samples checked against a behavioral
// model at every output handshake

`timescale 1ns/10ps

module tb_avg_top import avg_pkg::*; ();

  localparam int max_s = 2 ** (data_w - 1) - 1;
  localparam int min_s = -(2 ** (data_w - 1));
  localparam int cnt_max = 2 ** cnt_w - 1;

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  logic signed [data_w-1:0] in_data;
  logic out_valid;
  logic out_ready;
  logic signed [data_w-1:0] out_data;
  logic out_clipped;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [1:0] wb_adr;
  logic [data_w-1:0] wb_dat_w;
  logic [data_w-1:0] wb_dat_r;
  logic wb_ack;

  // model state
  int win [filter_len];
  bit win_clip [filter_len];
  int cur_offset;
  int cur_decim;
  int dec_count;
  int clip_total;
  int exp_data_q[$];
  bit exp_clip_q[$];

  avg_top u_avg_top (.*);

  always #10 clk = ~clk;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // inputs and checks both move one delay step past the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  task automatic model_clear();
    for (int i = 0; i < filter_len; i++) begin
      win[i] = 0;
      win_clip[i] = 0;
    end
    dec_count = 0;
  endtask

  task automatic model_accept(input int x);
    int diff;
    int sum;
    bit clip;
    bit any_clip;
    diff = x - cur_offset;
    clip = (diff > max_s) || (diff < min_s);
    if (diff > max_s) diff = max_s;
    if (diff < min_s) diff = min_s;
    if (clip && clip_total != cnt_max) clip_total++;
    for (int i = filter_len - 1; i > 0; i--) begin
      win[i] = win[i-1];
      win_clip[i] = win_clip[i-1];
    end
    win[0] = diff;
    win_clip[0] = clip;
    sum = 0;
    any_clip = 0;
    for (int i = 0; i < filter_len; i++) begin
      sum += win[i];
      any_clip |= win_clip[i];
    end
    // integer divide truncates toward zero
    if (dec_count == cur_decim) begin
      exp_data_q.push_back(sum / filter_len);
      exp_clip_q.push_back(any_clip);
      dec_count = 0;
    end else begin
      dec_count++;
    end
  endtask

  // sampled mid-cycle where all handshake signals have settled
  always @(negedge clk) begin
    if (!rst && in_valid && in_ready) model_accept(int'(in_data));
    if (!rst && out_valid && out_ready) begin
      assert (exp_data_q.size() > 0) else
        stop_with_error($sformatf("output at %0t with no average expected", $time));
      assert (int'(out_data) == exp_data_q[0]) else
        stop_with_error($sformatf("ERR t=%0t out_data expected %0d got %0d",
                                  $time, exp_data_q[0], out_data));
      assert (out_clipped == exp_clip_q[0]) else
        stop_with_error($sformatf("ERR t=%0t out_clipped expected %0b got %0b",
                                  $time, exp_clip_q[0], out_clipped));
      void'(exp_data_q.pop_front());
      void'(exp_clip_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////
  // wishbone and stream drivers
  ////////////////////////////////////////////////////////////

  task automatic wb_access(input reg_addr_e adr, input logic we,
                           input logic [data_w-1:0] wdat, output logic [data_w-1:0] rdat);
    int n;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    n = 0;
    do begin
      step();
      n++;
      assert (n < 20) else stop_with_error("wishbone access never acknowledged");
    end while (!wb_ack);
    rdat = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    step();
    assert (!wb_ack) else stop_with_error("wishbone access acknowledged twice");
  endtask

  // write the register and mirror its effect in the model
  task automatic reg_write(input reg_addr_e adr, input logic [data_w-1:0] wdat);
    logic [data_w-1:0] unused;
    wb_access(adr, 1'b1, wdat, unused);
    case (adr)
      reg_offset: cur_offset = int'($signed(wdat));
      reg_decim:  cur_decim = int'(wdat[decim_w-1:0]);
      reg_ctrl:   if (wdat[0]) model_clear();
      default:    clip_total = 0;
    endcase
  endtask

  task automatic reg_check(input reg_addr_e adr, input logic [data_w-1:0] expect_val);
    logic [data_w-1:0] rdat;
    wb_access(adr, 1'b0, '0, rdat);
    assert (rdat === expect_val) else
      stop_with_error($sformatf("ERR t=%0t wb_dat_r expected %0h got %0h",
                                $time, expect_val, rdat));
  endtask

  // full-range samples, half of them on the rails when extreme
  function automatic logic signed [data_w-1:0] pick_sample(input bit extreme);
    logic [31:0] r;
    r = $urandom();
    if (extreme && r[31:30] == 2'd0) return max_s[data_w-1:0];
    if (extreme && r[31:30] == 2'd1) return min_s[data_w-1:0];
    return r[data_w-1:0];
  endfunction

  task automatic stream_samples(input int n, input int gap_pct, input int stall_pct,
                                input bit extreme);
    int sent;
    int guard;
    bit took;
    sent = 0;
    guard = 0;
    while (sent < n) begin
      // a waiting sample is held until it transfers
      if (!in_valid && int'($urandom_range(99)) >= gap_pct) begin
        in_valid = 1'b1;
        in_data = pick_sample(extreme);
      end
      out_ready = int'($urandom_range(99)) >= stall_pct;
      @(negedge clk);
      took = in_valid && in_ready;
      step();
      if (took) begin
        sent++;
        in_valid = 1'b0;
      end
      guard++;
      assert (guard < n * 40 + 100) else stop_with_error("input stream stalled");
    end
  endtask

  // kept and dropped averages both leave within three cycles
  task automatic drain_pipeline();
    int n;
    in_valid = 1'b0;
    out_ready = 1'b1;
    n = 0;
    while (exp_data_q.size() != 0) begin
      step();
      n++;
      assert (n < 500) else stop_with_error("expected averages never arrived");
    end
    repeat (4) step();
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int ratio;
    void'($urandom(71));
    clk = 0;
    rst = 1;
    in_valid = 0;
    in_data = '0;
    out_ready = 0;
    wb_cyc = 0;
    wb_stb = 0;
    wb_we = 0;
    wb_adr = '0;
    wb_dat_w = '0;
    cur_offset = 0;
    cur_decim = 0;
    clip_total = 0;
    model_clear();
    repeat (3) @(posedge clk);
    #1;
    rst = 0;

    // register access
    reg_write(reg_offset, 16'h1234);
    reg_write(reg_decim, 16'h0005);
    reg_check(reg_offset, 16'h1234);
    reg_check(reg_decim, 16'h0005);
    reg_check(reg_ctrl, 16'h0000);
    reg_write(reg_offset, 16'h0000);
    reg_write(reg_decim, 16'h0000);

    // plain average with one output per sample
    stream_samples(300, 0, 0, 1'b0);
    drain_pipeline();

    // saturation both ways and the clip counter
    reg_write(reg_offset, 16'd20000);
    stream_samples(100, 10, 0, 1'b1);
    drain_pipeline();
    reg_write(reg_offset, -16'sd20000);
    stream_samples(100, 10, 0, 1'b1);
    drain_pipeline();
    reg_check(reg_status, clip_total[data_w-1:0]);
    reg_write(reg_status, 16'h0000);
    reg_check(reg_status, 16'h0000);

    // decimation over whole multiples of the ratio
    // so the count is back at zero afterwards
    reg_write(reg_offset, 16'h0000);
    ratio = int'($urandom_range(16, 2));
    reg_write(reg_decim, 16'(ratio - 1));
    stream_samples(20 * ratio, 0, 0, 1'b0);
    drain_pipeline();

    // back-pressure with gaps
    reg_write(reg_decim, 16'h0000);
    stream_samples(300, 30, 40, 1'b0);
    drain_pipeline();
    reg_write(reg_decim, 16'h0002);
    stream_samples(200, 30, 40, 1'b1);
    drain_pipeline();

    // clear restarts the window and the count
    reg_write(reg_decim, 16'h0003);
    reg_write(reg_ctrl, 16'h0001);
    stream_samples(100, 20, 20, 1'b0);
    drain_pipeline();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/avg_pkg.sv
verilog/sample_if.sv
verilog/sample_clip.sv
verilog/boxcar_avg.sv
verilog/avg_decimate.sv
verilog/wb_regs.sv
verilog/avg_top.sv
sim/tb_avg_top.sv

// ==== Makefile ====
# Verilator build and run for the averaging pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_avg_top
DUT_TOP   ?= avg_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the testbench printed the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) \
		verilog/avg_pkg.sv verilog/sample_if.sv verilog/sample_clip.sv \
		verilog/boxcar_avg.sv verilog/avg_decimate.sv verilog/wb_regs.sv \
		verilog/avg_top.sv

clean:
	rm -rf $(BUILD_DIR)
